//--- tb.f
+incdir+source
source/fft_pkg.sv
source/complex_multiplier.sv
source/twiddle_rom.sv
source/iterative_butterfly.sv
source/fft_butterfly_unit.sv
bench/tb_clock.sv
bench/butterfly_checker.sv
bench/butterfly_tb.sv

//--- Makefile
# Verilator build and run for the FFT butterfly unit testbench

VERILATOR  ?= verilator
TOP        := butterfly_tb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --assert -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# pass only when the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "\*\* PASS \*\*" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/butterfly_tb.sv
// testbench top that runs table driven batches with consumer stalls through the butterfly unit
`default_nettype none
`timescale 1ns/1ps

`include "fft_defines.svh"

module butterfly_tb;

  localparam int NUM_DIRECTED   = 6;
  localparam int NUM_RANDOM     = 12;
  localparam int NUM_ROWS       = NUM_DIRECTED + NUM_RANDOM;
  localparam int MAX_STALL      = 6;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * (`FFT_LANES + 4 + MAX_STALL) + 50;

  logic                clk;
  logic                reset;
  logic                recv_val;
  logic                recv_rdy;
  logic                send_val;
  logic                send_rdy;
  fft_pkg::bfly_req_t  req;
  fft_pkg::bfly_resp_t resp;
  int                  value_errors;
  int                  protocol_errors;
  int                  transfers;
  int                  bench_errors = 0;
  int                  cycle_count  = 0;

  // stimulus table with one batch per row
  string               row_name[NUM_ROWS];
  int                  row_stall[NUM_ROWS];
  fft_pkg::bfly_req_t  row_req[NUM_ROWS];
  fft_pkg::bfly_resp_t row_exp[NUM_ROWS];

  tb_clock clk_gen (.clk(clk));

  fft_butterfly_unit dut0 (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .req      (req),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .resp     (resp)
  );

  butterfly_checker chk0 (
    .clk             (clk),
    .reset           (reset),
    .recv_val        (recv_val),
    .recv_rdy        (recv_rdy),
    .req             (req),
    .send_val        (send_val),
    .send_rdy        (send_rdy),
    .resp            (resp),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors),
    .transfers       (transfers)
  );

  // ==========================================================================
  // reference arithmetic
  // ==========================================================================

  // round to nearest in units of 2^-14 with ties away from zero
  function automatic int round_q14(input real x);
    real s;
    s = x * 16384.0;
    if (s >= 0.0) begin
      return $rtoi(s + 0.5);
    end else begin
      return -$rtoi(0.5 - s);
    end
  endfunction

  // W16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16)
  function automatic fft_pkg::cplx_t twiddle_of(input fft_pkg::tw_idx_t k);
    real            ang;
    fft_pkg::cplx_t w;
    ang  = 2.0 * 3.14159265358979 * real'(k) / 16.0;
    w.re = fft_pkg::fixed_t'(round_q14($cos(ang)));
    w.im = fft_pkg::fixed_t'(-round_q14($sin(ang)));
    return w;
  endfunction

  function automatic fft_pkg::lane_resp_t butterfly_model(input fft_pkg::lane_req_t q);
    fft_pkg::cplx_t      w;
    fft_pkg::cplx_t      p;
    fft_pkg::lane_resp_t r;
    longint              pre;
    longint              pim;
    w   = twiddle_of(q.tw);
    // exact product floored by 2^14 with only the low word kept
    pre = longint'(q.b.re) * longint'(w.re) - longint'(q.b.im) * longint'(w.im);
    pim = longint'(q.b.re) * longint'(w.im) + longint'(q.b.im) * longint'(w.re);
    p.re = fft_pkg::fixed_t'(pre >>> `FFT_FRAC_BITS);
    p.im = fft_pkg::fixed_t'(pim >>> `FFT_FRAC_BITS);
    // sums wrap in 16 bits
    r.c.re = q.a.re + p.re;
    r.c.im = q.a.im + p.im;
    r.d.re = q.a.re - p.re;
    r.d.im = q.a.im - p.im;
    return r;
  endfunction

  // ==========================================================================
  // table setup
  // ==========================================================================

  // lane i gets operands offset from the row base that wrap past full scale
  task automatic set_row(input int r, input string name, input int stall,
                         input int ar, input int ai, input int br, input int bi,
                         input int k0, input int k1, input int k2, input int k3);
    int ks[4];
    ks = '{k0, k1, k2, k3};
    row_name[r]  = name;
    row_stall[r] = stall;
    for (int i = 0; i < `FFT_LANES; i++) begin
      row_req[r][i].a.re = fft_pkg::fixed_t'(ar + i * 4099);
      row_req[r][i].a.im = fft_pkg::fixed_t'(ai - i * 2053);
      row_req[r][i].b.re = fft_pkg::fixed_t'(br - i * 3001);
      row_req[r][i].b.im = fft_pkg::fixed_t'(bi + i * 1237);
      row_req[r][i].tw   = fft_pkg::tw_idx_t'(ks[i % 4]);
    end
  endtask

  task automatic fill_table();
    // name, stall, a base, b base, twiddle per lane
    set_row(0, "tw0_identity", 0, 1000, -2000, 300, 400, 0, 0, 0, 0);
    set_row(1, "tw4_rotate", 0, -5000, 7000, 1234, -4321, 4, 4, 4, 4);
    set_row(2, "tw_mixed", 1, 12345, -4321, -777, 555, 1, 2, 3, 5);
    set_row(3, "stall_hold", MAX_STALL, -16000, 9000, 20000, -20000, 6, 7, 0, 4);
    set_row(4, "back_to_back", 0, 3, -3, -32768, 32767, 2, 3, 4, 5);
    set_row(5, "wrap_overflow", 0, 32767, 32767, 32767, -32768, 0, 4, 2, 6);
    // random operands with each lane stepping through all eight twiddles
    for (int r = NUM_DIRECTED; r < NUM_ROWS; r++) begin
      row_name[r]  = $sformatf("random_%0d", r);
      row_stall[r] = $urandom % (MAX_STALL + 1);
      for (int i = 0; i < `FFT_LANES; i++) begin
        row_req[r][i].a.re = fft_pkg::fixed_t'($urandom);
        row_req[r][i].a.im = fft_pkg::fixed_t'($urandom);
        row_req[r][i].b.re = fft_pkg::fixed_t'($urandom);
        row_req[r][i].b.im = fft_pkg::fixed_t'($urandom);
        row_req[r][i].tw   = fft_pkg::tw_idx_t'(r + i);
      end
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int i = 0; i < `FFT_LANES; i++) begin
        row_exp[r][i] = butterfly_model(row_req[r][i]);
      end
    end
  endtask

  // ==========================================================================
  // drive loop
  // ==========================================================================

  // offer one batch and take its result after the row's stall count
  task automatic run_row(input int r);
    logic accepted;
    logic moved;
    int   stall_cnt;
    accepted  = 1'b0;
    moved     = 1'b0;
    stall_cnt = 0;
    recv_val <= 1'b1;
    req      <= row_req[r];
    while (!accepted) begin
      @(posedge clk);
      accepted = recv_rdy;
    end
    chk0.expect_batch(row_name[r], row_exp[r]);
    recv_val <= 1'b0;
    send_rdy <= (row_stall[r] == 0);
    while (!moved) begin
      @(posedge clk);
      if (send_val && send_rdy) begin
        moved = 1'b1;
      end else if (send_val) begin
        stall_cnt++;
        if (stall_cnt >= row_stall[r]) begin
          send_rdy <= 1'b1;
          recv_val <= 1'b0;
        end else begin
          // re-offer the batch while stalled to show the unit refuses it
          recv_val <= 1'b1;
        end
      end
    end
    send_rdy <= 1'b0;
  endtask

  task automatic print_counts();
    $display("value errors %0d, protocol errors %0d, bench errors %0d, batches %0d of %0d",
             value_errors, protocol_errors, bench_errors, transfers, NUM_ROWS);
  endtask

  initial begin
    void'($urandom(32'h345b61f4));
    reset    = 1'b1;
    recv_val = 1'b0;
    send_rdy = 1'b0;
    req      = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_req[r] = '0;
    end
    fill_table();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // idle cycles so the post-reset state is seen before any input
    repeat (2) @(posedge clk);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    repeat (3) @(posedge clk);
    if (transfers != NUM_ROWS) begin
      bench_errors++;
      $display("only %0d of %0d batches came out of the unit", transfers, NUM_ROWS);
    end
    print_counts();
    if (value_errors + protocol_errors + bench_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // hang guard sized from the row count and the longest stall
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles, a handshake never completed",
               TIMEOUT_CYCLES);
      print_counts();
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- bench/butterfly_checker.sv
// butterfly unit checker that compares each output batch and the handshake timing
`default_nettype none
`timescale 1ns/1ps

`include "fft_defines.svh"

module butterfly_checker (
  input  logic                clk,
  input  logic                reset,
  input  logic                recv_val,
  input  logic                recv_rdy,
  input  fft_pkg::bfly_req_t  req,
  input  logic                send_val,
  input  logic                send_rdy,
  input  fft_pkg::bfly_resp_t resp,
  output int                  value_errors,
  output int                  protocol_errors,
  output int                  transfers
);

  // expected batches in acceptance order, filled by the bench
  string               name_q[$];
  fft_pkg::bfly_resp_t exp_q[$];
  // operands as the unit took them
  fft_pkg::bfly_req_t  req_q[$];

  int                  n_value      = 0;
  int                  n_proto      = 0;
  int                  n_xfer       = 0;
  int                  since_accept = 0;
  logic                fresh_reset  = 1'b0;
  logic                in_flight    = 1'b0;
  logic                seen_val     = 1'b0;
  logic                stalled      = 1'b0;
  logic                rdy_due      = 1'b0;
  fft_pkg::bfly_resp_t held_resp;

  assign value_errors    = n_value;
  assign protocol_errors = n_proto;
  assign transfers       = n_xfer;

  task automatic expect_batch(input string name, input fft_pkg::bfly_resp_t exp);
    name_q.push_back(name);
    exp_q.push_back(exp);
  endtask

  // one output transfer against the oldest expected batch
  task automatic compare_batch();
    string               name;
    string               op_txt;
    string               exp_txt;
    string               act_txt;
    fft_pkg::bfly_resp_t exp;
    fft_pkg::bfly_req_t  ops;
    ops = '0;
    if (req_q.size() != 0) begin
      ops = req_q.pop_front();
    end
    if (exp_q.size() == 0) begin
      n_proto++;
      $display("an output transfer happened with no batch outstanding");
    end else begin
      name = name_q.pop_front();
      exp  = exp_q.pop_front();
      for (int i = 0; i < `FFT_LANES; i++) begin
        if (resp[i] !== exp[i]) begin
          n_value++;
          op_txt  = $sformatf("a=(%0d,%0d) b=(%0d,%0d) tw=%0d", ops[i].a.re, ops[i].a.im,
                              ops[i].b.re, ops[i].b.im, ops[i].tw);
          exp_txt = $sformatf("c=(%0d,%0d) d=(%0d,%0d)", exp[i].c.re, exp[i].c.im,
                              exp[i].d.re, exp[i].d.im);
          act_txt = $sformatf("c=(%0d,%0d) d=(%0d,%0d)", resp[i].c.re, resp[i].c.im,
                              resp[i].d.re, resp[i].d.im);
          $display("error %s lane %0d %s expected %s actual %s", name, i, op_txt,
                   exp_txt, act_txt);
        end
      end
    end
  endtask

  // ==========================================================================
  // port monitor sampling pre-edge values at each rising edge
  // ==========================================================================

  always @(posedge clk) begin
    if (reset) begin
      fresh_reset = 1'b1;
      in_flight   = 1'b0;
      stalled     = 1'b0;
      rdy_due     = 1'b0;
    end else begin
      // first cycle out of reset before any batch
      if (fresh_reset) begin
        fresh_reset = 1'b0;
        if (!recv_rdy || send_val || resp !== '0) begin
          n_proto++;
          $display("after reset the unit was not idle with cleared results");
        end
      end
      if (rdy_due) begin
        rdy_due = 1'b0;
        if (!recv_rdy) begin
          n_proto++;
          $display("recv_rdy did not return in the cycle after an output transfer");
        end
      end
      // held output must not move or drop while the consumer stalls
      if (stalled && (!send_val || resp !== held_resp)) begin
        n_proto++;
        $display("send_val or resp changed while send_rdy was low");
      end
      if (in_flight) begin
        since_accept++;
        if (recv_rdy) begin
          n_proto++;
          $display("recv_rdy went high while a batch was still in flight");
        end
        // first valid cycle counted from the accepting edge
        if (send_val && !seen_val) begin
          seen_val = 1'b1;
          if (since_accept - 1 != `FFT_LANES) begin
            n_proto++;
            $display("send_val rose %0d cycles after acceptance instead of %0d",
                     since_accept - 1, `FFT_LANES);
          end
        end
        if (send_val && send_rdy) begin
          compare_batch();
          n_xfer++;
          in_flight = 1'b0;
          rdy_due   = 1'b1;
        end
      end else begin
        if (send_val) begin
          n_proto++;
          $display("send_val was high with no batch in flight");
        end
        if (recv_val && recv_rdy) begin
          req_q.push_back(req);
          in_flight    = 1'b1;
          seen_val     = 1'b0;
          since_accept = 0;
        end
      end
      stalled   = send_val && !send_rdy;
      held_resp = resp;
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
// testbench clock source, free running with a 100 ns period
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // low at time zero, first rising edge at 50 ns
  initial begin
    clk = 1'b0;
  end

  // half period of 50 ns
  always #50 clk = ~clk;

endmodule

`default_nettype wire

//--- source/fft_butterfly_unit.sv
// radix-2 FFT butterfly unit top, per-lane twiddle tables feeding one iterative core
`default_nettype none
`timescale 1ns/1ps

`include "fft_defines.svh"

module fft_butterfly_unit (
  input  logic                clk,
  input  logic                reset,
  // input batch
  input  logic                recv_val,
  output logic                recv_rdy,
  input  fft_pkg::bfly_req_t  req,
  // output batch
  output logic                send_val,
  input  logic                send_rdy,
  output fft_pkg::bfly_resp_t resp
);

  // ==========================================================================
  // twiddle lookup
  // ==========================================================================

  // resolved twiddles, captured by the core together with req
  fft_pkg::twiddle_vec_t tw_vec;

  genvar i;
  generate
    for (i = 0; i < `FFT_LANES; i++) begin : g_tw
      twiddle_rom tw_rom (
        .idx (req[i].tw),
        .w   (tw_vec[i])
      );
    end
  endgenerate

  // ==========================================================================
  // butterfly core
  // ==========================================================================

  iterative_butterfly bfly (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .req      (req),
    .tw       (tw_vec),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .resp     (resp)
  );

endmodule

`default_nettype wire

//--- source/iterative_butterfly.sv
// iterative radix-2 butterfly that runs one lane per cycle through a shared multiplier
`default_nettype none
`timescale 1ns/1ps

`include "fft_defines.svh"

module iterative_butterfly (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  recv_val,
  output logic                  recv_rdy,
  input  fft_pkg::bfly_req_t    req,
  input  fft_pkg::twiddle_vec_t tw,
  output logic                  send_val,
  input  logic                  send_rdy,
  output fft_pkg::bfly_resp_t   resp
);

  // ==========================================================================
  // declarations
  // ==========================================================================

  // captured operands with one entry per lane
  fft_pkg::cplx_t [`FFT_LANES-1:0] a_q;
  fft_pkg::cplx_t [`FFT_LANES-1:0] b_q;
  fft_pkg::twiddle_vec_t           w_q;

  // results that drive resp directly
  fft_pkg::bfly_resp_t resp_q;

  // control
  fft_pkg::bfly_state_e          state;
  fft_pkg::bfly_state_e          state_nxt;
  logic [$clog2(`FFT_LANES)-1:0] lane;
  logic                          last_lane;
  logic                          accept;

  // datapath of the lane being worked on
  fft_pkg::cplx_t      cur_a;
  fft_pkg::cplx_t      cur_b;
  fft_pkg::cplx_t      cur_w;
  fft_pkg::cplx_t      prod;
  fft_pkg::lane_resp_t lane_res;

  // ==========================================================================
  // handshake
  // ==========================================================================

  assign recv_rdy = (state == fft_pkg::idle);
  assign send_val = (state == fft_pkg::done);
  assign accept   = recv_val && recv_rdy;
  assign resp     = resp_q;

  assign last_lane = (lane == ($clog2(`FFT_LANES))'(`FFT_LANES - 1));

  // ==========================================================================
  // FSM
  // ==========================================================================

  always_comb begin
    state_nxt = state;
    case (state)
      fft_pkg::idle: begin
        if (recv_val) begin
          state_nxt = fft_pkg::comp;
        end
      end
      // one lane per edge until the last one
      fft_pkg::comp: begin
        if (last_lane) begin
          state_nxt = fft_pkg::done;
        end
      end
      // hold the result until the consumer takes it
      fft_pkg::done: begin
        if (send_rdy) begin
          state_nxt = fft_pkg::idle;
        end
      end
      default: state_nxt = fft_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fft_pkg::idle;
      lane  <= '0;
    end else begin
      state <= state_nxt;
      // counter walks 0 upward while computing and returns to 0 for the next batch
      if (state == fft_pkg::comp) begin
        if (last_lane) begin
          lane <= '0;
        end else begin
          lane <= lane + 1'b1;
        end
      end
    end
  end

  // ==========================================================================
  // operand capture
  // ==========================================================================

  // tw indices are already resolved to twiddles one level up
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < `FFT_LANES; i++) begin
        a_q[i] <= req[i].a;
        b_q[i] <= req[i].b;
      end
      w_q <= tw;
    end
  end

  // ==========================================================================
  // shared multiplier and lane update
  // ==========================================================================

  assign cur_a = a_q[lane];
  assign cur_b = b_q[lane];
  assign cur_w = w_q[lane];

  complex_multiplier cmul (
    .x (cur_b),
    .y (cur_w),
    .p (prod)
  );

  // sums wrap modulo 2^16 without saturation
  assign lane_res.c.re = cur_a.re + prod.re;
  assign lane_res.c.im = cur_a.im + prod.im;
  assign lane_res.d.re = cur_a.re - prod.re;
  assign lane_res.d.im = cur_a.im - prod.im;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_q <= '0;
    end else if (state == fft_pkg::comp) begin
      resp_q[lane] <= lane_res;
    end
  end

  // ==========================================================================
  // assertions
  // ==========================================================================

  // result valid exactly FFT_LANES cycles after the accepting edge
  a_result_timing: assert property (@(posedge clk) disable iff (reset)
    accept |-> ##(`FFT_LANES + 1) send_val);

  // a stalled consumer sees the same result and valid until it takes it
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (send_val && !send_rdy) |=> (send_val && $stable(resp)));

  // lane counter wraps after the last lane and rests at zero between batches
  a_lane_idle: assert property (@(posedge clk) disable iff (reset)
    (state != fft_pkg::comp) |-> (lane == '0));

endmodule

`default_nettype wire

//--- source/twiddle_rom.sv
// twiddle table, maps index k to the Q1.14 root of unity W16^k
`default_nettype none
`timescale 1ns/1ps

`include "fft_defines.svh"

module twiddle_rom (
  input  fft_pkg::tw_idx_t idx,
  output fft_pkg::cplx_t   w
);

  // ==========================================================================
  // W16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16)
  // ==========================================================================

  // each entry is round(value * 2^14)
  // only the upper half circle is needed, k stops at 7
  always_comb begin
    case (idx)
      // k=0, angle 0
      3'd0: begin
        w.re = fft_pkg::fixed_t'(16384);
        w.im = fft_pkg::fixed_t'(0);
      end
      // k=1, cos 22.5 = 0.92388, sin 22.5 = 0.38268
      3'd1: begin
        w.re = fft_pkg::fixed_t'(15137);
        w.im = fft_pkg::fixed_t'(-6270);
      end
      // k=2, 45 deg, 0.70711 both ways
      3'd2: begin
        w.re = fft_pkg::fixed_t'(11585);
        w.im = fft_pkg::fixed_t'(-11585);
      end
      // k=3, 67.5 deg
      3'd3: begin
        w.re = fft_pkg::fixed_t'(6270);
        w.im = fft_pkg::fixed_t'(-15137);
      end
      // k=4, -j
      3'd4: begin
        w.re = fft_pkg::fixed_t'(0);
        w.im = fft_pkg::fixed_t'(-16384);
      end
      // k=5, 112.5 deg, cosine turns negative
      3'd5: begin
        w.re = fft_pkg::fixed_t'(-6270);
        w.im = fft_pkg::fixed_t'(-15137);
      end
      // k=6, 135 deg
      3'd6: begin
        w.re = fft_pkg::fixed_t'(-11585);
        w.im = fft_pkg::fixed_t'(-11585);
      end
      // k=7, 157.5 deg
      3'd7: begin
        w.re = fft_pkg::fixed_t'(-15137);
        w.im = fft_pkg::fixed_t'(-6270);
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/complex_multiplier.sv
// combinational three-multiplier fixed-point complex product with truncation
`default_nettype none
`timescale 1ns/1ps

`include "fft_defines.svh"

module complex_multiplier (
  input  fft_pkg::cplx_t x,
  input  fft_pkg::cplx_t y,
  output fft_pkg::cplx_t p
);

  // ==========================================================================
  // operand unpacking
  // ==========================================================================

  // plain signed copies so every product below is a signed product
  fft_pkg::fixed_t xr;
  fft_pkg::fixed_t xi;
  fft_pkg::fixed_t yr;
  fft_pkg::fixed_t yi;

  assign xr = x.re;
  assign xi = x.im;
  assign yr = y.re;
  assign yi = y.im;

  // ==========================================================================
  // Gauss arrangement
  // ==========================================================================

  // pre-adders, one extra bit so the sums never wrap
  logic signed [`FFT_WIDTH:0] sum_x;
  logic signed [`FFT_WIDTH:0] dif_y;
  logic signed [`FFT_WIDTH:0] sum_y;

  // products of a (W+1) and a W bit operand fit in 2W+1 bits
  logic signed [2*`FFT_WIDTH:0] k1;
  logic signed [2*`FFT_WIDTH:0] k2;
  logic signed [2*`FFT_WIDTH:0] k3;

  // exact parts, one more bit for the final add or subtract
  logic signed [2*`FFT_WIDTH+1:0] re_full;
  logic signed [2*`FFT_WIDTH+1:0] im_full;

  assign sum_x = xr + xi;
  assign dif_y = yi - yr;
  assign sum_y = yr + yi;

  // k1 = yr*(xr+xi), k2 = xr*(yi-yr), k3 = xi*(yr+yi)
  assign k1 = yr * sum_x;
  assign k2 = xr * dif_y;
  assign k3 = xi * sum_y;

  // re = xr*yr - xi*yi
  assign re_full = k1 - k3;
  // im = xr*yi + xi*yr
  assign im_full = k1 + k2;

  // ==========================================================================
  // rescale
  // ==========================================================================

  // arithmetic shift floors toward minus infinity, then keep the low word
  assign p.re = fft_pkg::fixed_t'(re_full >>> `FFT_FRAC_BITS);
  assign p.im = fft_pkg::fixed_t'(im_full >>> `FFT_FRAC_BITS);

endmodule

`default_nettype wire

//--- source/fft_pkg.sv
// shared fixed-point, complex, lane and FSM types for the butterfly unit
`default_nettype none

`include "fft_defines.svh"

package fft_pkg;

  // ========================================================================
  // scalar and complex words
  // ========================================================================

  // signed Q1.14 word
  typedef logic signed [`FFT_WIDTH-1:0] fixed_t;

  // complex value, re in the upper half
  typedef struct packed {
    fixed_t re;
    fixed_t im;
  } cplx_t;

  // index k of the twiddle W16^k
  typedef logic [`FFT_TW_BITS-1:0] tw_idx_t;

  // ========================================================================
  // lane and batch payloads
  // ========================================================================

  // operands of one butterfly
  typedef struct packed {
    cplx_t   a;
    cplx_t   b;
    tw_idx_t tw;
  } lane_req_t;

  // c = a + w*b, d = a - w*b
  typedef struct packed {
    cplx_t c;
    cplx_t d;
  } lane_resp_t;

  typedef lane_req_t  [`FFT_LANES-1:0] bfly_req_t;
  typedef lane_resp_t [`FFT_LANES-1:0] bfly_resp_t;
  typedef cplx_t      [`FFT_LANES-1:0] twiddle_vec_t;

  // butterfly control states
  typedef enum logic [1:0] {
    idle = 2'd0,
    comp = 2'd1,
    done = 2'd2
  } bfly_state_e;

endpackage

`default_nettype wire

//--- source/fft_defines.svh
// fixed-point FFT butterfly width and lane count definitions
`ifndef FFT_DEFINES_SVH
`define FFT_DEFINES_SVH

// ==========================================================================
// word format
// ==========================================================================

// two's complement word width of one real or imaginary part
`define FFT_WIDTH 16

// fraction bits, Q1.14 for a 16 bit word
`define FFT_FRAC_BITS 14

// ==========================================================================
// batch shape
// ==========================================================================

// butterflies per batch, one lane handled per clock
// 2, 4 or 8 all work
`define FFT_LANES 4

// twiddle index width, picks k = 0..7 of W16^k
`define FFT_TW_BITS 3

`endif
